/* source/hb_consts.svh */
// Widths, pipeline depths, register map and taps of the halfband decimator, included by its RTL
`ifndef HB_CONSTS_SVH
`define HB_CONSTS_SVH

`define HB_WIDTH      24           // External sample width
`define HB_INTWIDTH   17           // Rounded internal sample, fits 18-bit multiplier after pair add
`define HB_ACCWIDTH   36           // Product and accumulator width
`define HB_SHIFT      6            // Places centre sample in output scale
`define HB_OUT_DELAY  11           // Odd stb_in to stb_out, in clocks

`define HB_ADDR_CTRL  2'd0         // Bit 0 run, bit 1 bypass
`define HB_ADDR_CPI   2'd1         // Clocks per input
`define HB_CPI_RESET  9'd2

// Symmetric taps, outer to inner, scaled by 2^18; centre tap of one half is implicit
`define HB_C0 (-18'sd107)
`define HB_C1 (18'sd445)
`define HB_C2 (-18'sd1271)
`define HB_C3 (18'sd2959)
`define HB_C4 (-18'sd6107)
`define HB_C5 (18'sd11953)
`define HB_C6 (-18'sd24706)
`define HB_C7 (18'sd82359)

`endif

/* source/hb_pkg.sv */
// Shared sample, coefficient and control types of the halfband decimator
`include "hb_consts.svh"

package hb_pkg;

   // External sample as seen on the ports
   typedef logic signed [`HB_WIDTH-1:0] sample_t;

   // Input rounded for the multipliers
   typedef logic signed [`HB_INTWIDTH-1:0] int_sample_t;

   // Filter tap, 18-bit multiplier operand
   typedef logic signed [17:0] coeff_t;

   // Tap sequencing, 0 idle and 1 to 4 active
   typedef logic [2:0] phase_t;

   // Clocks per input sample
   typedef logic [8:0] cpi_t;

endpackage

/* source/srl.sv */
// Addressable 16-deep sample shift register, one per filter read port
module srl (
   input  logic                clk,
   input  logic                rst,
   input  logic                write,   // Shift in new sample
   input  hb_pkg::int_sample_t in,
   input  logic [3:0]          addr,    // 0 is the newest sample
   output hb_pkg::int_sample_t out
);

   hb_pkg::int_sample_t mem [16];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 16; i++) mem[i] <= '0;   // Defined history for first outputs
      end else if (write) begin
         mem[0] <= in;
         for (int i = 1; i < 16; i++) mem[i] <= mem[i-1];
      end
   end

   assign out = mem[addr];                // Combinational read

endmodule

/* source/hb_ctrl_regs.sv */
// Wishbone classic register slave holding run, bypass and cpi for the halfband decimator
`include "hb_consts.svh"

module hb_ctrl_regs (
   input  logic         clk,
   input  logic         rst,
   input  logic         wb_cyc,
   input  logic         wb_stb,
   input  logic         wb_we,
   input  logic [1:0]   wb_adr,     // Word address
   input  logic [31:0]  wb_dat_w,
   output logic [31:0]  wb_dat_r,
   output logic         wb_ack,
   output logic         run,
   output logic         bypass,
   output hb_pkg::cpi_t cpi
);

   localparam int CPI_W = $bits(hb_pkg::cpi_t);

   logic req;                           // New request, not yet acked

   assign req = wb_cyc & wb_stb & ~wb_ack;   // No back-to-back ack

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_ack <= 1'b0;
         run    <= 1'b0;
         bypass <= 1'b0;
         cpi    <= `HB_CPI_RESET;
      end else begin
         wb_ack <= req;
         if (req && wb_we) begin                        // Write lands with the ack edge
            if (wb_adr == `HB_ADDR_CTRL) begin
               run    <= wb_dat_w[0];
               bypass <= wb_dat_w[1];
            end
            if (wb_adr == `HB_ADDR_CPI) cpi <= wb_dat_w[CPI_W-1:0];
         end
      end
   end

   // Read data, valid with ack
   always_ff @(posedge clk) begin
      if (req) begin
         case (wb_adr)
            `HB_ADDR_CTRL: wb_dat_r <= {30'b0, bypass, run};
            `HB_ADDR_CPI:  wb_dat_r <= 32'(cpi);
            default:       wb_dat_r <= '0;              // Unmapped
         endcase
      end
   end

endmodule

/* source/hb_dec.sv */
// Halfband decimate-by-2 filter core with input rounding, two multiply lanes and bypass, used by the stage top level
`include "hb_consts.svh"

module hb_dec (
   input  logic            clk,
   input  logic            rst,
   input  logic            run,        // Low holds pairing and taps idle
   input  logic            bypass,     // Pass input through with one register
   input  hb_pkg::cpi_t    cpi,        // Clocks per input picking the centre tap delay
   input  logic            stb_in,
   input  hb_pkg::sample_t data_in,
   output logic            stb_out,
   output hb_pkg::sample_t data_out
);

   localparam int PRE_LEN  = `HB_OUT_DELAY - 2;        // Odd rounded strobe to final sum
   localparam int RND_DROP = `HB_WIDTH - `HB_INTWIDTH; // Input LSBs dropped
   localparam int SUM_W    = `HB_WIDTH + 1;            // Rounded acc and final sum
   localparam int ACC_DROP = `HB_ACCWIDTH - SUM_W;     // Acc LSBs dropped

   logic signed [`HB_WIDTH:0]    rnd_sum;              // Input plus half LSB
   logic signed [`HB_INTWIDTH:0] rnd_q;                // Before saturation
   hb_pkg::int_sample_t          rnd_sat;
   logic                         stb_rnd;
   hb_pkg::int_sample_t          data_rnd;

   logic                         odd;                  // Next rounded sample closes a pair
   logic                         write_odd;
   logic                         write_even;
   hb_pkg::phase_t               phase;
   hb_pkg::phase_t               phase_d1;             // Aligned with pair sums
   logic [PRE_LEN-1:0]           stb_pre;              // One bit per result in flight
   logic [1:0]                   tap_idx;
   logic [3:0]                   addr_a, addr_b, addr_c, addr_d;
   logic [3:0]                   addr_even;

   hb_pkg::int_sample_t          odd_a, odd_b, odd_c, odd_d;
   hb_pkg::int_sample_t          data_even;
   logic signed [`HB_INTWIDTH:0] sum_o, sum_i;         // 18-bit multiplier inputs
   hb_pkg::coeff_t               coeff_o, coeff_i;
   logic signed [`HB_ACCWIDTH-1:0] prod_o, prod_i;
   logic signed [`HB_ACCWIDTH-1:0] sum_prod;
   logic signed [`HB_ACCWIDTH-1:0] acc;
   logic                         clear;
   logic                         do_acc;
   logic signed [SUM_W-1:0]      acc_rnd;
   logic signed [SUM_W-1:0]      even_ext;
   logic signed [SUM_W-1:0]      final_sum;
   hb_pkg::sample_t              final_clip;
   logic                         sel_stb;

   // Input rounding to nearest with ties up
   assign rnd_sum = {data_in[`HB_WIDTH-1], data_in} + SUM_W'(1 << (RND_DROP - 1));
   assign rnd_q   = rnd_sum[`HB_WIDTH:RND_DROP];

   always_comb begin
      if (rnd_q[`HB_INTWIDTH] != rnd_q[`HB_INTWIDTH-1])   // Only max can round past range
         rnd_sat = {1'b0, {(`HB_INTWIDTH-1){1'b1}}};
      else
         rnd_sat = rnd_q[`HB_INTWIDTH-1:0];
   end

   always_ff @(posedge clk) begin
      if (rst) stb_rnd <= 1'b0;
      else     stb_rnd <= stb_in;
   end

   always_ff @(posedge clk) begin
      if (stb_in) data_rnd <= rnd_sat;
   end

   // Pairing and tap sequencing
   always_ff @(posedge clk) begin
      if (rst || !run)  odd <= 1'b0;
      else if (stb_rnd) odd <= ~odd;
   end

   assign write_odd  = stb_rnd & odd;
   assign write_even = stb_rnd & ~odd;

   always_ff @(posedge clk) begin
      if (rst || !run)                phase <= '0;
      else if (write_odd)             phase <= 3'd1;        // Start of four tap phases
      else if (phase == 3'd4)         phase <= '0;
      else if (phase != '0)           phase <= phase + 3'd1;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         phase_d1 <= '0;
         stb_pre  <= '0;
      end else begin
         phase_d1 <= phase;
         stb_pre  <= {stb_pre[PRE_LEN-2:0], write_odd};
      end
   end

   // Symmetric read addresses for pairs (i, 15-i) and (i+4, 11-i)
   assign tap_idx = (phase == '0) ? 2'd0 : 2'(phase - 3'd1);
   assign addr_a  = {2'b00, tap_idx};
   assign addr_b  = 4'd15 - addr_a;
   assign addr_c  = addr_a + 4'd4;
   assign addr_d  = 4'd11 - addr_a;

   always_ff @(posedge clk) begin
      case (cpi)
         9'd2:                          addr_even <= 4'd9;  // Fastest input rate
         9'd3, 9'd4, 9'd5, 9'd6, 9'd7:  addr_even <= 4'd8;
         default:                       addr_even <= 4'd7;
      endcase
   end

   srl i_srl_odd_a  (.clk(clk), .rst(rst), .write(write_odd),  .in(data_rnd),
                     .addr(addr_a), .out(odd_a));
   srl i_srl_odd_b  (.clk(clk), .rst(rst), .write(write_odd),  .in(data_rnd),
                     .addr(addr_b), .out(odd_b));
   srl i_srl_odd_c  (.clk(clk), .rst(rst), .write(write_odd),  .in(data_rnd),
                     .addr(addr_c), .out(odd_c));
   srl i_srl_odd_d  (.clk(clk), .rst(rst), .write(write_odd),  .in(data_rnd),
                     .addr(addr_d), .out(odd_d));
   srl i_srl_even   (.clk(clk), .rst(rst), .write(write_even), .in(data_rnd),
                     .addr(addr_even), .out(data_even));

   always_comb begin
      case (phase_d1)
         3'd2: begin
            coeff_o = `HB_C1;
            coeff_i = `HB_C5;
         end
         3'd3: begin
            coeff_o = `HB_C2;
            coeff_i = `HB_C6;
         end
         3'd4: begin
            coeff_o = `HB_C3;
            coeff_i = `HB_C7;
         end
         default: begin                 // Phase 1 and idle
            coeff_o = `HB_C0;
            coeff_i = `HB_C4;
         end
      endcase
   end

   // Two-lane multiply-add pipeline
   always_ff @(posedge clk) begin
      sum_o    <= (`HB_INTWIDTH+1)'(odd_a) + (`HB_INTWIDTH+1)'(odd_b);   // Outer pair
      sum_i    <= (`HB_INTWIDTH+1)'(odd_c) + (`HB_INTWIDTH+1)'(odd_d);   // Inner pair
      prod_o   <= sum_o * coeff_o;
      prod_i   <= sum_i * coeff_i;
      sum_prod <= prod_o + prod_i;                                       // Cannot overflow
   end

   assign clear  = stb_pre[3];          // First phase reaches the accumulator
   assign do_acc = |stb_pre[6:3];

   always_ff @(posedge clk) begin
      if (clear)       acc <= sum_prod;
      else if (do_acc) acc <= acc + sum_prod;
   end

   // Output rounding, centre tap and clipping
   assign acc_rnd  = SUM_W'((acc + `HB_ACCWIDTH'(1 << (ACC_DROP - 1))) >>> ACC_DROP);
   assign even_ext = SUM_W'(data_even) <<< `HB_SHIFT;   // Centre tap of one half

   always_ff @(posedge clk) begin
      final_sum <= acc_rnd + even_ext;
   end

   always_comb begin
      if (final_sum[SUM_W-1] != final_sum[SUM_W-2])
         final_clip = final_sum[SUM_W-1] ? {1'b1, {(`HB_WIDTH-1){1'b0}}}
                                          : {1'b0, {(`HB_WIDTH-1){1'b1}}};
      else
         final_clip = final_sum[`HB_WIDTH-1:0];
   end

   assign sel_stb = bypass ? stb_in : stb_pre[PRE_LEN-1];

   always_ff @(posedge clk) begin
      if (rst) stb_out <= 1'b0;
      else     stb_out <= sel_stb;
   end

   always_ff @(posedge clk) begin
      if (sel_stb) data_out <= bypass ? data_in : final_clip;   // Held between strobes
   end

endmodule

/* source/hb_dec_top.sv */
// Top level of the halfband decimator stage, register slave plus filter core on plain ports
module hb_dec_top (
   input  logic            clk,
   input  logic            rst,
   input  logic            wb_cyc,
   input  logic            wb_stb,
   input  logic            wb_we,
   input  logic [1:0]      wb_adr,
   input  logic [31:0]     wb_dat_w,
   output logic [31:0]     wb_dat_r,
   output logic            wb_ack,
   input  logic            stb_in,     // No faster than every cpi clocks
   input  hb_pkg::sample_t data_in,
   output logic            stb_out,
   output hb_pkg::sample_t data_out
);

   logic         run;
   logic         bypass;
   hb_pkg::cpi_t cpi;

   hb_ctrl_regs i_regs (
      .clk(clk), .rst(rst),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .run(run), .bypass(bypass), .cpi(cpi)
   );

   hb_dec i_dec (
      .clk(clk), .rst(rst),
      .run(run), .bypass(bypass), .cpi(cpi),
      .stb_in(stb_in), .data_in(data_in),
      .stb_out(stb_out), .data_out(data_out)
   );

endmodule

/* verif/hb_dec_assertions.sv */
// Bus and strobe protocol checks, bound to the halfband decimator top level
module hb_dec_assertions (
   input logic clk,
   input logic rst,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_ack,
   input logic bypass,
   input logic stb_out
);
   timeunit 1ns;
   timeprecision 100ps;

   // Ack only answers a request seen on the previous clock
   ack_after_req: assert property (@(posedge clk) disable iff (rst)
      wb_ack |-> $past(wb_cyc && wb_stb))
      else $error("wb_ack without a request one clock earlier");

   // Single-cycle ack
   ack_single: assert property (@(posedge clk) disable iff (rst)
      wb_ack |=> !wb_ack)
      else $error("wb_ack high for two clocks");

   // Decimated strobe cannot come back to back
   stb_spacing: assert property (@(posedge clk) disable iff (rst)
      (!bypass && stb_out) |=> !stb_out)
      else $error("stb_out on two consecutive clocks while filtering");

endmodule

bind hb_dec_top hb_dec_assertions i_assertions (
   .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
   .bypass(bypass), .stb_out(stb_out)
);

/* verif/tb_hb_dec.sv */
// Top-level testbench of the halfband decimator checking registers, bypass, filtering and run control
`include "hb_consts.svh"

module tb_hb_dec;
   timeunit 1ns;
   timeprecision 100ps;

   logic        clk;
   logic        rst;
   logic        wb_cyc, wb_stb, wb_we;
   logic [1:0]  wb_adr;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_dat_r;
   logic        wb_ack;
   logic        stb_in;
   logic [23:0] data_in;
   logic        stb_out;
   logic [23:0] data_out;

   int          seed = 99;
   int          errors = 0;
   int          tests = 0;
   int          err_mark;
   int          cyc_n = 0;                // Posedge counter used by the model
   logic        run_m = 1'b0;             // Register mirrors
   logic        byp_m = 1'b0;
   int          cpi_m = 2;

   // Reference model state
   int          odd_h [16];
   int          even_h [16];
   logic        pair_odd;                 // Next sample closes a pair
   logic        even_pend;                // Even sample lands one clock after strobe
   int          even_val;
   int          due_cyc [$];              // Centre tap read points
   longint      due_acc [$];
   logic [23:0] exp_data [$];
   int          exp_cyc [$];
   int          coef [8];

   hb_dec_top i_dut (
      .clk(clk), .rst(rst),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .stb_in(stb_in), .data_in(data_in), .stb_out(stb_out), .data_out(data_out)
   );

   always #5 clk = ~clk;

   // Round to 17 bits nearest with ties up and saturate
   function automatic int round_in(input logic signed [23:0] x);
      int r;
      r = (int'(x) + 64) >>> 7;
      if (r > 65535) r = 65535;
      else if (r < -65536) r = -65536;
      return r;
   endfunction

   function automatic int centre_addr(input int c);
      if (c == 2) return 9;
      else if (c >= 3 && c <= 7) return 8;
      else return 7;
   endfunction

   function automatic logic [23:0] clip24(input longint v);
      if (v > 64'sd8388607) return 24'h7fffff;
      else if (v < -64'sd8388608) return 24'h800000;
      else return 24'(v);
   endfunction

   // Model and output checker sampling at each rising edge
   always @(posedge clk) begin
      longint acc;
      longint tot;
      int     r;
      if (rst) begin
         pair_odd  = 1'b0;
         even_pend = 1'b0;
         for (int i = 0; i < 16; i++) begin
            odd_h[i]  = 0;
            even_h[i] = 0;
         end
      end else begin
         // Final sum formed with centre tap read before this edge's write
         while (due_cyc.size() != 0 && due_cyc[0] == cyc_n) begin
            void'(due_cyc.pop_front());
            acc = due_acc.pop_front();
            tot = ((acc + 1024) >>> 11) + longint'(even_h[centre_addr(cpi_m)]) * 64;
            exp_data.push_back(clip24(tot));
            exp_cyc.push_back(cyc_n + 2);
         end
         if (even_pend) begin
            for (int i = 15; i > 0; i--) even_h[i] = even_h[i-1];
            even_h[0] = even_val;
            even_pend = 1'b0;
         end
         if (!run_m) pair_odd = 1'b0;     // Pairing held while stopped
         if (stb_in) begin
            r = round_in(data_in);
            if (byp_m) begin
               exp_data.push_back(data_in);
               exp_cyc.push_back(cyc_n + 1);
            end
            if (!pair_odd) begin
               even_pend = 1'b1;
               even_val  = r;
            end else begin
               for (int i = 15; i > 0; i--) odd_h[i] = odd_h[i-1];
               odd_h[0] = r;
               acc = 0;
               for (int i = 0; i < 8; i++)
                  acc += longint'(coef[i]) * longint'(odd_h[i] + odd_h[15-i]);
               if (!byp_m) begin
                  due_cyc.push_back(cyc_n + `HB_OUT_DELAY - 2);
                  due_acc.push_back(acc);
               end
            end
            if (run_m) pair_odd = ~pair_odd;
         end
         if (stb_out) begin
            assert (exp_data.size() != 0)
            else begin
               $display("%0t: stb_out with no expected output pending", $time);
               errors++;
            end
            if (exp_data.size() != 0) begin
               assert (data_out == exp_data[0])
               else begin
                  $display("ERR %0t data_out exp %h got %h", $time, exp_data[0], data_out);
                  errors++;
               end
               assert (cyc_n == exp_cyc[0])
               else begin
                  $display("%0t: stb_out at cycle %0d, expected at cycle %0d",
                           $time, cyc_n, exp_cyc[0]);
                  errors++;
               end
               void'(exp_data.pop_front());
               void'(exp_cyc.pop_front());
            end
         end
      end
      cyc_n++;
   end

   task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
      int t;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = 1'b1;
      wb_adr = adr;
      wb_dat_w = dat;
      t = 0;
      do begin
         @(negedge clk);
         t++;
      end while (!wb_ack && t < 20);
      assert (wb_ack)
      else begin
         $display("%0t: write to address %0d got no ack", $time, adr);
         errors++;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      if (adr == `HB_ADDR_CTRL) begin
         run_m = dat[0];
         byp_m = dat[1];
      end
      if (adr == `HB_ADDR_CPI) cpi_m = int'(dat[8:0]);
   endtask

   task automatic wb_read_check(input logic [1:0] adr, input logic [31:0] exp);
      int t;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = 1'b0;
      wb_adr = adr;
      t = 0;
      do begin
         @(negedge clk);
         t++;
      end while (!wb_ack && t < 20);
      assert (wb_ack)
      else begin
         $display("%0t: read of address %0d got no ack", $time, adr);
         errors++;
      end
      assert (wb_dat_r == exp)
      else begin
         $display("ERR %0t wb_dat_r exp %h got %h", $time, exp, wb_dat_r);
         errors++;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   // One strobe then idle until the next is cpi clocks away
   task automatic drive_sample(input logic [23:0] v);
      stb_in = 1'b1;
      data_in = v;
      @(negedge clk);
      stb_in = 1'b0;
      repeat (cpi_m - 1) @(negedge clk);
   endtask

   // Sixteen pairs with odd samples following the tap signs push the last output past full scale
   task automatic drive_clip_run(input logic neg);
      logic pos;
      for (int j = 0; j < 16; j++) begin
         pos = ((j % 2 == 1) != (j >= 8)) != neg;
         drive_sample(neg ? 24'h800000 : 24'h7fffff);   // Even centre sample
         drive_sample(pos ? 24'h7fffff : 24'h800000);
      end
   endtask

   task automatic wait_drain();
      int t;
      t = 0;
      while ((exp_data.size() != 0 || due_cyc.size() != 0) && t < 400) begin
         @(negedge clk);
         t++;
      end
      assert (exp_data.size() == 0 && due_cyc.size() == 0)
      else begin
         $display("%0t: timeout, expected outputs never arrived", $time);
         errors++;
      end
      repeat (4) @(negedge clk);
   endtask

   task automatic restart(input int c, input logic [31:0] ctrl);
      wb_write(`HB_ADDR_CTRL, 32'd0);      // Stop clears pairing
      wb_write(`HB_ADDR_CPI, 32'(c));
      wb_write(`HB_ADDR_CTRL, ctrl);
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
      err_mark = errors;
   endtask

   task automatic filter_run(input int c, input int n);
      restart(c, 32'd1);
      for (int i = 0; i < n; i++) drive_sample(24'($random(seed)));
      wait_drain();
   endtask

   initial begin
      logic [31:0] v;
      coef = '{`HB_C0, `HB_C1, `HB_C2, `HB_C3, `HB_C4, `HB_C5, `HB_C6, `HB_C7};
      clk = 1'b0;
      rst = 1'b1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      stb_in = 1'b0;
      data_in = '0;
      err_mark = 0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      wb_read_check(`HB_ADDR_CTRL, 32'd0);   // Reset values
      wb_read_check(`HB_ADDR_CPI, 32'(`HB_CPI_RESET));
      for (int i = 0; i < 4; i++) begin
         v = 32'($random(seed)) & 32'h3;
         wb_write(`HB_ADDR_CTRL, v);
         wb_read_check(`HB_ADDR_CTRL, v);
         v = 32'($random(seed)) & 32'h1ff;
         wb_write(`HB_ADDR_CPI, v);
         wb_read_check(`HB_ADDR_CPI, v);
      end
      wb_read_check(2'd2, 32'd0);
      wb_read_check(2'd3, 32'd0);
      end_test("register access");

      restart(3, 32'd2);
      for (int i = 0; i < 50; i++) drive_sample(24'($random(seed)));
      wait_drain();
      end_test("bypass");

      filter_run(2, 400);
      end_test("filter cpi 2");
      filter_run(5, 200);
      end_test("filter cpi 5");
      filter_run(12, 100);
      end_test("filter cpi 12");

      restart(2, 32'd1);
      for (int i = 0; i < 60; i++) drive_sample(24'h7fffc0);   // Rounds past 17-bit max
      for (int i = 0; i < 60; i++) drive_sample(24'h7fffff);
      for (int i = 0; i < 60; i++) drive_sample(24'h800000);
      for (int i = 0; i < 60; i++)
         drive_sample((i % 3 == 0) ? 24'($random(seed)) : ((i % 2) ? 24'h7fffff : 24'h800000));
      drive_clip_run(1'b0);
      drive_clip_run(1'b1);
      wait_drain();
      end_test("saturation");

      filter_run(2, 40);
      wb_write(`HB_ADDR_CTRL, 32'd0);
      for (int i = 0; i < 40; i++) drive_sample(24'($random(seed)));   // None may come out
      wait_drain();
      wb_write(`HB_ADDR_CTRL, 32'd1);
      for (int i = 0; i < 100; i++) drive_sample(24'($random(seed)));
      wait_drain();
      end_test("run control");

      $display("tests %0d, errors %0d", tests, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* sim.f */
+incdir+source
source/hb_pkg.sv
source/srl.sv
source/hb_ctrl_regs.sv
source/hb_dec.sv
source/hb_dec_top.sv
verif/hb_dec_assertions.sv
verif/tb_hb_dec.sv

/* run_sim.sh */
#!/bin/sh
# Builds the halfband decimator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_hb_dec -o sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "RESULT: PASS" sim.log; then
   exit 0
else
   echo "Pass line not found in sim.log"
   exit 1
fi
